// File: common/radio_pkg.sv
// Shared types, settings bus addresses and reset values imported by every radio core RTL block
`default_nettype none

package radio_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths

   localparam int DAC_W    = 12;  // One DAC converter word
   localparam int SAMPLE_W = 24;  // I or Q after the DSP chain
   localparam int TIME_W   = 64;  // VITA time
   localparam int LED_W    = 8;

   ////////////////////////////////////////////////////////////////////////////
   // Settings bus address map

   localparam logic [7:0] SR_MISC        = 8'd0;    // 7 regs
   localparam logic [7:0] SR_TESTSIG     = 8'd8;    // One per DAC
   localparam logic [7:0] SR_TIME64      = 8'd10;
   localparam logic [7:0] SR_RX_FRONT_SW = 8'd176;
   localparam logic [7:0] SR_TX_FRONT_SW = 8'd177;
   localparam logic [7:0] SR_DIVSW       = 8'd180;  // 2 regs

   // Offsets inside the MISC block
   localparam logic [7:0] SR_LED_SW_OFS  = 8'd3;
   localparam logic [7:0] SR_BLDR_OFS    = 8'd5;
   localparam logic [7:0] SR_LED_SRC_OFS = 8'd6;

   // Offsets inside the TIME64 block
   localparam logic [7:0] SR_TIME_HI_OFS = 8'd0;
   localparam logic [7:0] SR_TIME_LO_OFS = 8'd1;  // Writing this one loads the time

   ////////////////////////////////////////////////////////////////////////////
   // Reset values

   // Run indicators on LEDs 4..1 by default
   localparam logic [LED_W-1:0] LED_SRC_RESET = 8'h1E;
   localparam logic [1:0]       DIVSW_RESET   = 2'b11;  // Both switches on

   ////////////////////////////////////////////////////////////////////////////
   // Bundles

   // One settings write valid for the single cycle where stb is high
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   typedef struct packed {
      logic [SAMPLE_W-1:0] i;
      logic [SAMPLE_W-1:0] q;
      logic                ovf_i;  // ADC overflow on the I side
      logic                ovf_q;  // ADC overflow on the Q side
      logic                run;
   } rx_sample_t;

   typedef struct packed {
      logic [SAMPLE_W-1:0] i;
      logic [SAMPLE_W-1:0] q;
      logic                run;
   } tx_sample_t;

   typedef struct packed {
      logic [DAC_W-1:0] a;
      logic [DAC_W-1:0] b;
   } dac_pair_t;

   typedef struct packed {
      logic              stb;    // Single cycle
      logic [TIME_W-1:0] value;
   } time_load_t;

endpackage

`default_nettype wire

// File: frontend/frontend_switch.sv
// Registered straight-or-crossed two-channel front-end switch; one instance per sample type
`timescale 1ns/1ps
`default_nettype none

module frontend_switch #(
   parameter type payload_t = logic
) (
   input  wire      dsp_clk,
   input  wire      por_rst,
   input  wire      core_rst_i,
   input  wire      swap_i,      // 1 = channels crossed
   input  payload_t ch0_i,
   input  payload_t ch1_i,
   output payload_t ch0_o,
   output payload_t ch1_o
);

   payload_t ch0_q;
   payload_t ch1_q;

   // One cycle of latency in both modes
   always_ff @(posedge dsp_clk) begin
      if (por_rst || core_rst_i) begin
         ch0_q <= '0;
         ch1_q <= '0;
      end else if (swap_i) begin
         ch0_q <= ch1_i;  // Crossed
         ch1_q <= ch0_i;
      end else begin
         ch0_q <= ch0_i;
         ch1_q <= ch1_i;
      end
   end

   assign ch0_o = ch0_q;
   assign ch1_o = ch1_q;

endmodule

`default_nettype wire

// File: boot_ctrl/boot_ctrl_fsm.sv
// Boot control; holds boot mode until the bootloader reports done, then pulses the core reset
`timescale 1ns/1ps
`default_nettype none

module boot_ctrl_fsm (
   input  wire  dsp_clk,
   input  wire  por_rst,
   input  wire  bldr_done_i,   // Set by the bootloader over the settings bus
   output logic core_rst_o,    // One cycle
   output logic boot_mode_o
);

   typedef enum logic {
      ST_WAIT = 1'b0,
      ST_DONE = 1'b1
   } boot_state_t;

   boot_state_t state;
   logic        core_rst;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state    <= ST_WAIT;
         core_rst <= 1'b0;
      end else begin
         case (state)
            ST_WAIT: begin
               core_rst <= 1'b0;
               if (bldr_done_i) begin
                  state    <= ST_DONE;
                  core_rst <= 1'b1;  // Restart the core once
               end
            end

            // Only por_rst leaves this state
            ST_DONE: begin
               core_rst <= 1'b0;
            end

            default: begin
               state    <= ST_WAIT;
               core_rst <= 1'b0;
            end
         endcase
      end
   end

   assign core_rst_o  = core_rst;
   assign boot_mode_o = (state == ST_WAIT);

endmodule

`default_nettype wire

// File: timing/vita_timer.sv
// 64-bit VITA time counter; loaded from the settings bank, captured on each PPS rising edge
`timescale 1ns/1ps
`default_nettype none

module vita_timer (
   input  wire                          dsp_clk,
   input  wire                          por_rst,
   input  wire                          core_rst_i,
   input  radio_pkg::time_load_t        time_load_i,
   input  wire                          pps_i,          // Asynchronous
   output logic [radio_pkg::TIME_W-1:0] vita_time_o,
   output logic [radio_pkg::TIME_W-1:0] vita_time_pps_o,
   output logic                         pps_int_o
);

   import radio_pkg::*;

   logic [TIME_W-1:0] vita_time;
   logic [TIME_W-1:0] vita_time_pps;
   logic              pps_int;
   logic              pps_meta;
   logic              pps_sync;
   logic              pps_del;
   logic              pps_edge;

   ////////////////////////////////////////////////////////////////////////////
   // PPS synchronizer and edge detect

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_del  <= 1'b0;
      end else begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_del  <= pps_sync;
      end
   end

   assign pps_edge = pps_sync & ~pps_del;  // Rising

   ////////////////////////////////////////////////////////////////////////////
   // Time counter

   always_ff @(posedge dsp_clk) begin
      if (por_rst || core_rst_i) begin
         vita_time <= '0;
      end else if (time_load_i.stb) begin
         vita_time <= time_load_i.value;
      end else begin
         vita_time <= vita_time + 64'd1;
      end
   end

   // Capture the current time; one less than the counter while pps_int is up
   always_ff @(posedge dsp_clk) begin
      if (por_rst || core_rst_i) begin
         vita_time_pps <= '0;
         pps_int       <= 1'b0;
      end else begin
         pps_int <= pps_edge;
         if (pps_edge) begin
            vita_time_pps <= vita_time;
         end
      end
   end

   assign vita_time_o     = vita_time;
   assign vita_time_pps_o = vita_time_pps;
   assign pps_int_o       = pps_int;

endmodule

`default_nettype wire

// File: hdl/misc_ctrl_regs.sv
// Settings bus register bank; decodes writes and drives LEDs, diversity switches, DAC test words
`timescale 1ns/1ps
`default_nettype none

module misc_ctrl_regs (
   input  wire                          dsp_clk,
   input  wire                          por_rst,
   input  radio_pkg::set_bus_t          set_i,
   input  wire [radio_pkg::LED_W-1:0]   led_hw_i,     // Hardware run indicators
   output logic [radio_pkg::LED_W-1:0]  leds_o,
   output logic [1:0]                   div_sw_o,
   output radio_pkg::dac_pair_t         dac0_o,
   output radio_pkg::dac_pair_t         dac1_o,
   output logic                         rx_swap_o,
   output logic                         tx_swap_o,
   output logic                         bldr_done_o,
   output radio_pkg::time_load_t        time_load_o
);

   import radio_pkg::*;

   logic [LED_W-1:0] led_sw;     // Software pattern
   logic [LED_W-1:0] led_src;    // 1 = hardware, 0 = software
   logic [1:0]       div_sw;
   logic [31:0]      testsig0;
   logic [31:0]      testsig1;
   logic             rx_swap;
   logic             tx_swap;
   logic             bldr_done;
   logic [31:0]      time_hi;    // Held until the low word arrives
   time_load_t       time_load;

   ////////////////////////////////////////////////////////////////////////////
   // Write decode

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         led_sw    <= '0;
         led_src   <= LED_SRC_RESET;
         div_sw    <= DIVSW_RESET;
         testsig0  <= '0;
         testsig1  <= '0;
         rx_swap   <= 1'b0;
         tx_swap   <= 1'b0;
         bldr_done <= 1'b0;
         time_hi   <= '0;
         time_load <= '0;
      end else begin
         time_load.stb <= 1'b0;  // Pulse
         if (set_i.stb) begin
            case (set_i.addr)
               SR_MISC + SR_LED_SW_OFS:  led_sw    <= set_i.data[LED_W-1:0];
               SR_MISC + SR_BLDR_OFS:    bldr_done <= set_i.data[0];
               SR_MISC + SR_LED_SRC_OFS: led_src   <= set_i.data[LED_W-1:0];
               SR_TESTSIG:               testsig0  <= set_i.data;
               SR_TESTSIG + 8'd1:        testsig1  <= set_i.data;
               SR_TIME64 + SR_TIME_HI_OFS: time_hi <= set_i.data;
               SR_TIME64 + SR_TIME_LO_OFS: begin
                  // Low word completes the 64-bit value
                  time_load.stb   <= 1'b1;
                  time_load.value <= {time_hi, set_i.data};
               end
               SR_RX_FRONT_SW:           rx_swap   <= set_i.data[0];
               SR_TX_FRONT_SW:           tx_swap   <= set_i.data[0];
               SR_DIVSW:                 div_sw[0] <= set_i.data[0];
               SR_DIVSW + 8'd1:          div_sw[1] <= set_i.data[0];
               default: ;
            endcase
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Outputs

   // Per-bit choice between hardware and software
   assign leds_o = (led_src & led_hw_i) | (~led_src & led_sw);

   // Top 12 bits of each half go to the DAC
   assign dac0_o.a = testsig0[31:20];
   assign dac0_o.b = testsig0[15:4];
   assign dac1_o.a = testsig1[31:20];
   assign dac1_o.b = testsig1[15:4];

   assign div_sw_o    = div_sw;
   assign rx_swap_o   = rx_swap;
   assign tx_swap_o   = tx_swap;
   assign bldr_done_o = bldr_done;
   assign time_load_o = time_load;  // Timer applies it on the next edge

endmodule

`default_nettype wire

// File: hdl/radio_core.sv
// Radio core top level; wires settings bank, boot FSM, VITA timer and front-end switches
`timescale 1ns/1ps
`default_nettype none

module radio_core (
   input  wire                          dsp_clk,
   input  wire                          por_rst,
   input  radio_pkg::set_bus_t          set_i,
   input  wire                          pps_i,

   // Samples from the DSP chains
   input  radio_pkg::rx_sample_t        rx0_i,
   input  radio_pkg::rx_sample_t        rx1_i,
   input  radio_pkg::tx_sample_t        tx0_i,
   input  radio_pkg::tx_sample_t        tx1_i,

   // Samples after the front-end switches
   output radio_pkg::rx_sample_t        rx0_o,
   output radio_pkg::rx_sample_t        rx1_o,
   output radio_pkg::tx_sample_t        tx0_o,
   output radio_pkg::tx_sample_t        tx1_o,

   output logic [radio_pkg::LED_W-1:0]  leds_o,
   output logic [1:0]                   div_sw_o,
   output radio_pkg::dac_pair_t         dac0_o,
   output radio_pkg::dac_pair_t         dac1_o,
   output logic [radio_pkg::TIME_W-1:0] vita_time_o,
   output logic [radio_pkg::TIME_W-1:0] vita_time_pps_o,
   output logic                         pps_int_o,
   output logic                         boot_mode_o
);

   import radio_pkg::*;

   logic             bldr_done;
   logic             core_rst;    // One-cycle pulse once the bootloader is done
   logic             rx_swap;
   logic             tx_swap;
   time_load_t       time_load;
   logic [LED_W-1:0] led_hw;

   // Run indicators after the swap, LEDs 4..1
   assign led_hw = {3'b000, tx0_o.run, rx0_o.run, tx1_o.run, rx1_o.run, 1'b0};

   ////////////////////////////////////////////////////////////////////////////
   // Settings and boot

   misc_ctrl_regs regs (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .set_i       (set_i),
      .led_hw_i    (led_hw),
      .leds_o      (leds_o),
      .div_sw_o    (div_sw_o),
      .dac0_o      (dac0_o),
      .dac1_o      (dac1_o),
      .rx_swap_o   (rx_swap),
      .tx_swap_o   (tx_swap),
      .bldr_done_o (bldr_done),
      .time_load_o (time_load)
   );

   boot_ctrl_fsm boot (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .bldr_done_i (bldr_done),
      .core_rst_o  (core_rst),
      .boot_mode_o (boot_mode_o)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Timing and front end

   vita_timer timer (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .core_rst_i      (core_rst),
      .time_load_i     (time_load),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time_o),
      .vita_time_pps_o (vita_time_pps_o),
      .pps_int_o       (pps_int_o)
   );

   frontend_switch #(.payload_t(rx_sample_t)) rx_sw (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .core_rst_i (core_rst),
      .swap_i     (rx_swap),
      .ch0_i      (rx0_i),
      .ch1_i      (rx1_i),
      .ch0_o      (rx0_o),
      .ch1_o      (rx1_o)
   );

   frontend_switch #(.payload_t(tx_sample_t)) tx_sw (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .core_rst_i (core_rst),
      .swap_i     (tx_swap),
      .ch0_i      (tx0_i),
      .ch1_i      (tx1_i),
      .ch0_o      (tx0_o),
      .ch1_o      (tx1_o)
   );

endmodule

`default_nettype wire

// File: verification/radio_core_tb.sv
// Self-checking testbench for radio_core; run with the radio_core.f file list, top radio_core_tb
`timescale 1ns/1ps
`default_nettype none

module radio_core_tb;

   import radio_pkg::*;

   typedef struct packed {
      logic [LED_W-1:0] leds;
      dac_pair_t        dac0;
      dac_pair_t        dac1;
   } reg_view_t;

   logic                dsp_clk;
   logic                por_rst;
   set_bus_t            set_i;
   logic                pps_i;
   rx_sample_t          rx0_i, rx1_i, rx0_o, rx1_o;
   tx_sample_t          tx0_i, tx1_i, tx0_o, tx1_o;
   logic [LED_W-1:0]    leds_o;
   logic [1:0]          div_sw_o;
   dac_pair_t           dac0_o, dac1_o;
   logic [TIME_W-1:0]   vita_time_o, vita_time_pps_o;
   logic                pps_int_o, boot_mode_o;

   logic [31:0]         lfsr;
   logic                stim_en;
   logic                check_en;

   // Shadow copy of the settings bank and the expected switch outputs
   logic [7:0]          led_sw_sh, led_src_sh;
   logic [1:0]          div_sw_sh;
   logic [31:0]         ts0_sh, ts1_sh;
   logic                rx_swap_sh, tx_swap_sh, bldr_sh;
   logic                boot_done_sh, core_rst_sh;
   rx_sample_t          rx0_exp, rx1_exp;
   tx_sample_t          tx0_exp, tx1_exp;

   radio_core dut0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_i(set_i), .pps_i(pps_i),
      .rx0_i(rx0_i), .rx1_i(rx1_i), .tx0_i(tx0_i), .tx1_i(tx1_i),
      .rx0_o(rx0_o), .rx1_o(rx1_o), .tx0_o(tx0_o), .tx1_o(tx1_o),
      .leds_o(leds_o), .div_sw_o(div_sw_o), .dac0_o(dac0_o), .dac1_o(dac1_o),
      .vita_time_o(vita_time_o), .vita_time_pps_o(vita_time_pps_o),
      .pps_int_o(pps_int_o), .boot_mode_o(boot_mode_o)
   );

   initial dsp_clk = 1'b0;
   always #10 dsp_clk = ~dsp_clk;  // 20 ns period

   ////////////////////////////////////////////////////////////////////////////
   // Helpers

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // One LFSR step per bit
   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v    = {v[62:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
      return v;
   endfunction

   // Random settings data of n bits
   function automatic logic [31:0] random_word(input int n);
      logic [63:0] v;
      v = take_bits(n);
      return v[31:0];
   endfunction

   // Expected LEDs and DAC pairs from the shadow registers
   function automatic reg_view_t predict_regs(input logic [7:0] sw, input logic [7:0] src,
                                              input logic [7:0] hw, input logic [31:0] ts0,
                                              input logic [31:0] ts1);
      reg_view_t v;
      for (int b = 0; b < LED_W; b++) begin
         v.leds[b] = src[b] ? hw[b] : sw[b];
      end
      v.dac0.a = ts0[31:20];
      v.dac0.b = ts0[15:4];
      v.dac1.a = ts1[31:20];
      v.dac1.b = ts1[15:4];
      return v;
   endfunction

   task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
         $display("Some tests failed");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   task automatic fail_timeout(input string what);
      $display("Timed out at %0t ns while waiting for %s", $time, what);
      $display("Some tests failed");
      $fatal(1, "Stopped on a timeout");
   endtask

   // Next rising edge with fresh random samples when enabled
   task automatic next_cycle();
      logic [63:0] r;
      @(posedge dsp_clk);
      if (stim_en) begin
         r = take_bits(51);
         rx0_i <= r[50:0];
         r = take_bits(51);
         rx1_i <= r[50:0];
         r = take_bits(49);
         tx0_i <= r[48:0];
         r = take_bits(49);
         tx1_i <= r[48:0];
      end
   endtask

   // Returns on the strobe edge
   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      next_cycle();
      set_i <= {1'b1, addr, data};
      next_cycle();
      set_i <= '0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference model updated from the inputs seen on each edge

   always @(posedge dsp_clk) begin
      if (por_rst) begin
         led_sw_sh    <= '0;
         led_src_sh   <= LED_SRC_RESET;
         div_sw_sh    <= DIVSW_RESET;
         ts0_sh       <= '0;
         ts1_sh       <= '0;
         rx_swap_sh   <= 1'b0;
         tx_swap_sh   <= 1'b0;
         bldr_sh      <= 1'b0;
         boot_done_sh <= 1'b0;
         core_rst_sh  <= 1'b0;
         rx0_exp      <= '0;
         rx1_exp      <= '0;
         tx0_exp      <= '0;
         tx1_exp      <= '0;
      end else begin
         if (core_rst_sh) begin
            rx0_exp <= '0;
            rx1_exp <= '0;
            tx0_exp <= '0;
            tx1_exp <= '0;
         end else begin
            rx0_exp <= rx_swap_sh ? rx1_i : rx0_i;
            rx1_exp <= rx_swap_sh ? rx0_i : rx1_i;
            tx0_exp <= tx_swap_sh ? tx1_i : tx0_i;
            tx1_exp <= tx_swap_sh ? tx0_i : tx1_i;
         end
         core_rst_sh  <= bldr_sh && !boot_done_sh;  // Single pulse
         boot_done_sh <= boot_done_sh || bldr_sh;
         if (set_i.stb) begin
            case (set_i.addr)
               SR_MISC + SR_LED_SW_OFS:    led_sw_sh    <= set_i.data[7:0];
               SR_MISC + SR_LED_SRC_OFS:   led_src_sh   <= set_i.data[7:0];
               SR_MISC + SR_BLDR_OFS:      bldr_sh      <= set_i.data[0];
               SR_TESTSIG:                 ts0_sh       <= set_i.data;
               SR_TESTSIG + 8'd1:          ts1_sh       <= set_i.data;
               SR_RX_FRONT_SW:             rx_swap_sh   <= set_i.data[0];
               SR_TX_FRONT_SW:             tx_swap_sh   <= set_i.data[0];
               SR_DIVSW:                   div_sw_sh[0] <= set_i.data[0];
               SR_DIVSW + 8'd1:            div_sw_sh[1] <= set_i.data[0];
               default: ;
            endcase
         end
      end
   end

   // Compare on the falling edge away from the driving edge
   always @(negedge dsp_clk) begin
      reg_view_t v;
      if (check_en) begin
         v = predict_regs(led_sw_sh, led_src_sh,
                          {3'b000, tx0_exp.run, rx0_exp.run, tx1_exp.run, rx1_exp.run, 1'b0},
                          ts0_sh, ts1_sh);
         check_equal(leds_o, v.leds, "leds_o");
         check_equal(dac0_o, v.dac0, "dac0_o");
         check_equal(dac1_o, v.dac1, "dac1_o");
         check_equal(div_sw_o, div_sw_sh, "div_sw_o");
         check_equal(rx0_o, rx0_exp, "rx0_o");
         check_equal(rx1_o, rx1_exp, "rx1_o");
         check_equal(tx0_o, tx0_exp, "tx0_o");
         check_equal(tx1_o, tx1_exp, "tx1_o");
         check_equal(boot_mode_o, !boot_done_sh, "boot_mode_o");
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      logic [31:0] hi;
      logic [31:0] lo;
      logic [63:0] t_before;
      dac_pair_t   dac0_keep;
      dac_pair_t   dac1_keep;
      logic        found;
      int          n;

      lfsr     = 32'h10f5a8a7;
      stim_en  = 1'b0;
      check_en = 1'b0;
      por_rst  = 1'b1;
      set_i    = '0;
      pps_i    = 1'b0;
      rx0_i    = '0;
      rx1_i    = '0;
      tx0_i    = '0;
      tx1_i    = '0;
      repeat (3) @(posedge dsp_clk);
      por_rst <= 1'b0;

      // Reset defaults
      @(negedge dsp_clk);
      check_equal(div_sw_o, 2'b11, "div_sw_o after reset");
      check_equal(boot_mode_o, 1'b1, "boot_mode_o after reset");
      check_equal(dac0_o, '0, "dac0_o after reset");
      check_equal(dac1_o, '0, "dac1_o after reset");
      check_equal(leds_o, '0, "leds_o after reset");
      check_en = 1'b1;
      stim_en  = 1'b1;

      // Register writes with random run flags feeding the LEDs
      for (n = 0; n < 8; n++) begin
         write_reg(SR_TESTSIG, random_word(32));
         write_reg(SR_TESTSIG + 8'd1, random_word(32));
         write_reg(SR_MISC + SR_LED_SW_OFS, random_word(8));
         write_reg(SR_MISC + SR_LED_SRC_OFS, random_word(8));
         write_reg(SR_DIVSW, random_word(1));
         write_reg(SR_DIVSW + 8'd1, random_word(1));
      end

      // Front-end switches in all four swap settings
      for (n = 0; n < 4; n++) begin
         write_reg(SR_RX_FRONT_SW, n[0]);
         write_reg(SR_TX_FRONT_SW, n[1]);
         repeat (12) next_cycle();
      end

      // Time load then count
      hi = random_word(32) | 32'h1;  // Nonzero so the boot restart is visible
      lo = random_word(32);
      write_reg(SR_TIME64 + SR_TIME_HI_OFS, hi);
      write_reg(SR_TIME64 + SR_TIME_LO_OFS, lo);
      next_cycle();
      @(negedge dsp_clk);
      check_equal(vita_time_o, {hi, lo}, "vita_time_o after load");
      for (n = 1; n < 6; n++) begin
         next_cycle();
         @(negedge dsp_clk);
         check_equal(vita_time_o, {hi, lo} + n, "vita_time_o counting");
      end

      // PPS capture
      next_cycle();
      pps_i <= 1'b1;
      found = 1'b0;
      for (n = 0; n < 10 && !found; n++) begin
         next_cycle();
         @(negedge dsp_clk);
         found = pps_int_o;
      end
      if (!found) fail_timeout("pps_int_o");
      check_equal(vita_time_pps_o, vita_time_o - 64'd1, "vita_time_pps_o");
      next_cycle();
      @(negedge dsp_clk);
      check_equal(pps_int_o, 1'b0, "pps_int_o width");
      next_cycle();
      pps_i <= 1'b0;

      // Boot control
      @(negedge dsp_clk);
      t_before  = vita_time_o;
      dac0_keep = dac0_o;
      dac1_keep = dac1_o;
      write_reg(SR_MISC + SR_BLDR_OFS, 32'd1);
      found = 1'b0;
      for (n = 0; n < 10 && !found; n++) begin
         @(negedge dsp_clk);
         found = !boot_mode_o;
         if (!found) next_cycle();
      end
      if (!found) fail_timeout("boot_mode_o to drop");
      next_cycle();
      @(negedge dsp_clk);
      check_equal(vita_time_o < t_before, 1'b1, "vita_time_o restart");
      check_equal(vita_time_o < 64'd4, 1'b1, "vita_time_o near zero");
      check_equal(rx0_o, '0, "rx0_o during core reset");
      check_equal(tx1_o, '0, "tx1_o during core reset");
      repeat (8) next_cycle();
      @(negedge dsp_clk);
      check_equal(dac0_o, dac0_keep, "dac0_o kept over core reset");
      check_equal(dac1_o, dac1_keep, "dac1_o kept over core reset");

      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: radio_core.f
common/radio_pkg.sv
frontend/frontend_switch.sv
boot_ctrl/boot_ctrl_fsm.sv
timing/vita_timer.sv
hdl/misc_ctrl_regs.sv
hdl/radio_core.sv
verification/radio_core_tb.sv
